// ==== all.f ====
hw/sdram_test_pkg.sv
hw/wb_burst_master.sv
hw/uart_tx.sv
hw/mem_self_test.sv
hw/sdram_self_test_top.sv
test/tb_sdram_self_test.sv

// ==== hw/mem_self_test.sv ====
`timescale 1ns/1ps

module mem_self_test
    import sdram_test_pkg::*;
#(
    parameter int GAP_CYCLES   = GAP_CYCLES_DEFAULT,
    parameter int REGION_WORDS = REGION_WORDS_DEFAULT
) (
    input  logic                   clk_133MHz_210,
    input  logic                   rst_n,

    // Burst request to the bus master.
    output logic                   start,
    output logic                   write,
    output logic [ADDR_W-1:0]      base_adr,
    output logic [DATA_W-1:0]      wr_value,
    output logic [BURST_IDX_W-1:0] rd_idx,
    input  logic [DATA_W-1:0]      rd_word,
    input  logic                   burst_done,

    // Byte request to the UART.
    output logic                   send,
    output logic [BYTE_W-1:0]      tx_byte,
    input  logic                   busy,

    // Status.
    output logic                   err_led,
    output logic                   done
);

    localparam logic [ADDR_W:0] REGION_END = (ADDR_W + 1)'(REGION_WORDS);

    typedef enum logic [2:0] {
        S_WRITE,      // First write after reset.
        S_WR_WAIT,
        S_RD_WAIT,
        S_REPORT,     // Compare and send bytes.
        S_GAP,
        S_ERR_WAIT,   // Error byte on the line.
        S_HALT,
        S_DONE
    } state_t;

    state_t                 state;
    logic [BURST_IDX_W:0]   byte_cnt;    // Word index and low-byte flag.
    logic [CNT_W-1:0]       gap_cnt;

    logic [ADDR_W:0]        next_adr;    // One bit wider for the region check.
    logic                   last_burst;
    logic                   word_ok;
    logic                   low_byte;
    logic                   tx_free;     // UART can take a byte.

    assign next_adr   = {1'b0, base_adr} + (ADDR_W + 1)'(BURST_LEN);
    assign last_burst = next_adr >= REGION_END;
    assign word_ok    = rd_word == wr_value;
    assign low_byte   = byte_cnt[0];
    assign rd_idx     = byte_cnt[BURST_IDX_W:1];
    assign tx_free    = !busy && !send;                    // Busy lags send by one cycle.

    ////////////////////////////////////////////////////////////
    // Test sequencer.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_WRITE;
            start    <= 1'b0;
            write    <= 1'b0;
            base_adr <= '0;
            wr_value <= '0;
            send     <= 1'b0;
            byte_cnt <= '0;
            gap_cnt  <= '0;
            err_led  <= 1'b0;
            done     <= 1'b0;
        end else begin
            start <= 1'b0;                                 // Pulses by default.
            send  <= 1'b0;
            case (state)
                S_WRITE: begin
                    start <= 1'b1;
                    write <= 1'b1;
                    state <= S_WR_WAIT;
                end
                S_WR_WAIT: begin
                    if (burst_done) begin
                        start <= 1'b1;                     // Read the same burst back.
                        write <= 1'b0;
                        state <= S_RD_WAIT;
                    end
                end
                S_RD_WAIT: begin
                    if (burst_done) begin
                        byte_cnt <= '0;
                        state    <= S_REPORT;
                    end
                end
                S_REPORT: begin
                    // Wait for the previous frame to finish.
                    if (tx_free) begin
                        send <= 1'b1;
                        if (!word_ok) begin
                            state <= S_ERR_WAIT;           // Report and stop.
                        end else if (byte_cnt == '1) begin
                            gap_cnt <= '0;
                            state   <= S_GAP;              // Eighth byte out.
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                S_GAP: begin
                    // Gap counts from the end of the last frame.
                    if (!tx_free) begin
                        gap_cnt <= '0;
                    end else if (last_burst) begin
                        done  <= 1'b1;
                        state <= S_DONE;
                    end else if (gap_cnt == CNT_W'(GAP_CYCLES - 1)) begin
                        base_adr <= next_adr[ADDR_W-1:0];  // Next four words.
                        wr_value <= wr_value + 1'b1;
                        start    <= 1'b1;
                        write    <= 1'b1;
                        state    <= S_WR_WAIT;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                S_ERR_WAIT: begin
                    if (tx_free) begin
                        err_led <= 1'b1;
                        state   <= S_HALT;
                    end
                end
                S_HALT: state <= S_HALT;                   // Wait for reset.
                S_DONE: state <= S_DONE;
                default: state <= S_HALT;
            endcase
        end
    end

    // Byte to send. High byte first, error code on mismatch.
    always_ff @(posedge clk_133MHz_210) begin
        if (state == S_REPORT && tx_free) begin
            if (!word_ok) begin
                tx_byte <= ERR_BYTE;
            end else if (low_byte) begin
                tx_byte <= rd_word[BYTE_W-1:0];
            end else begin
                tx_byte <= rd_word[DATA_W-1:BYTE_W];
            end
        end
    end

endmodule

// ==== hw/sdram_self_test_top.sv ====
`timescale 1ns/1ps

module sdram_self_test_top
    import sdram_test_pkg::*;
#(
    parameter int BAUD_DIV     = BAUD_DIV_DEFAULT,
    parameter int GAP_CYCLES   = GAP_CYCLES_DEFAULT,
    parameter int REGION_WORDS = REGION_WORDS_DEFAULT
) (
    input  logic              clk_133MHz_210,
    input  logic              rst_n,

    // Wishbone to the SDRAM controller.
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output logic [ADDR_W-1:0] wb_adr,
    output logic [DATA_W-1:0] wb_dat_w,
    input  logic [DATA_W-1:0] wb_dat_r,
    input  logic              wb_ack,

    output logic              uart_txd,
    output logic              err_led,   // Compare failure.
    output logic              done       // Whole region passed.
);

    ////////////////////////////////////////////////////////////
    // Sequencer to master and UART.
    ////////////////////////////////////////////////////////////

    logic                   start;
    logic                   write;
    logic [ADDR_W-1:0]      base_adr;
    logic [DATA_W-1:0]      wr_value;
    logic [BURST_IDX_W-1:0] rd_idx;
    logic [DATA_W-1:0]      rd_word;
    logic                   burst_done;
    logic                   send;
    logic [BYTE_W-1:0]      tx_byte;
    logic                   busy;

    mem_self_test #(
        .GAP_CYCLES   (GAP_CYCLES),
        .REGION_WORDS (REGION_WORDS)
    ) i_mem_self_test (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .start          (start),
        .write          (write),
        .base_adr       (base_adr),
        .wr_value       (wr_value),
        .rd_idx         (rd_idx),
        .rd_word        (rd_word),
        .burst_done     (burst_done),
        .send           (send),
        .tx_byte        (tx_byte),
        .busy           (busy),
        .err_led        (err_led),
        .done           (done)
    );

    wb_burst_master i_wb_burst_master (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .start          (start),
        .write          (write),
        .base_adr       (base_adr),
        .wr_value       (wr_value),
        .rd_idx         (rd_idx),
        .rd_word        (rd_word),
        .burst_done     (burst_done),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack)
    );

    uart_tx #(
        .BAUD_DIV (BAUD_DIV)
    ) i_uart_tx (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .send           (send),
        .tx_byte        (tx_byte),
        .busy           (busy),
        .uart_txd       (uart_txd)
    );

endmodule

// ==== hw/sdram_test_pkg.sv ====
package sdram_test_pkg;

    ////////////////////////////////////////////////////////////
    // Memory geometry.
    ////////////////////////////////////////////////////////////

    // Bank 2 + row 13 + column 9.
    localparam int ADDR_W = 24;
    localparam int DATA_W = 16;          // One SDRAM word.

    localparam int BURST_LEN   = 4;      // Words per burst.
    localparam int BURST_IDX_W = 2;      // Word index inside a burst.

    ////////////////////////////////////////////////////////////
    // Serial report.
    ////////////////////////////////////////////////////////////

    localparam int BYTE_W = 8;

    // Start bit, eight data bits LSB first, two stop bits.
    localparam int UART_FRAME_BITS = 11;

    // 133.33 MHz / 115200 baud.
    localparam int BAUD_DIV_DEFAULT = 1157;

    ////////////////////////////////////////////////////////////
    // Test pacing and coverage.
    ////////////////////////////////////////////////////////////

    localparam int GAP_CYCLES_DEFAULT = 2222222;   // Pause between bursts.

    // One 480 x 800 frame.
    localparam int REGION_WORDS_DEFAULT = 384000;

    localparam int CNT_W = 32;           // Baud and gap counters.

    // Sent in place of the data byte on a compare failure.
    localparam logic [BYTE_W-1:0] ERR_BYTE = 8'hEE;

endpackage

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
    import sdram_test_pkg::*;
#(
    parameter int BAUD_DIV = BAUD_DIV_DEFAULT   // Clock cycles per bit.
) (
    input  logic              clk_133MHz_210,
    input  logic              rst_n,
    input  logic              send,
    input  logic [BYTE_W-1:0] tx_byte,
    output logic              busy,
    output logic              uart_txd
);

    localparam int BIT_CNT_W = $clog2(UART_FRAME_BITS);

    logic [UART_FRAME_BITS-1:0] frame;      // Bit 0 is on the line.
    logic [CNT_W-1:0]           baud_cnt;   // Position inside one bit.
    logic [BIT_CNT_W-1:0]       bit_cnt;    // Bit being sent.

    logic                       baud_end;
    logic                       last_bit;

    assign baud_end = baud_cnt == CNT_W'(BAUD_DIV - 1);
    assign last_bit = bit_cnt == BIT_CNT_W'(UART_FRAME_BITS - 1);

    ////////////////////////////////////////////////////////////
    // Frame timing.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (send) begin
                busy     <= 1'b1;                   // Frame starts next cycle.
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_end) begin
            baud_cnt <= '0;
            if (last_bit) begin
                busy <= 1'b0;                       // Second stop bit done.
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // Shift register. Stop bits high, data LSB first, start bit low.
    always_ff @(posedge clk_133MHz_210) begin
        if (send && !busy) begin
            frame <= {2'b11, tx_byte, 1'b0};
        end else if (busy && baud_end) begin
            frame <= {1'b1, frame[UART_FRAME_BITS-1:1]};
        end
    end

    assign uart_txd = busy ? frame[0] : 1'b1;       // Idle high.

endmodule

// ==== hw/wb_burst_master.sv ====
`timescale 1ns/1ps

module wb_burst_master
    import sdram_test_pkg::*;
(
    input  logic                   clk_133MHz_210,
    input  logic                   rst_n,

    // Burst request from the sequencer.
    input  logic                   start,
    input  logic                   write,
    input  logic [ADDR_W-1:0]      base_adr,
    input  logic [DATA_W-1:0]      wr_value,
    input  logic [BURST_IDX_W-1:0] rd_idx,
    output logic [DATA_W-1:0]      rd_word,
    output logic                   burst_done,

    // Wishbone classic master.
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output logic [ADDR_W-1:0]      wb_adr,
    output logic [DATA_W-1:0]      wb_dat_w,
    input  logic [DATA_W-1:0]      wb_dat_r,
    input  logic                   wb_ack
);

    logic [BURST_IDX_W-1:0] word_cnt;   // Word in flight.
    logic                   we_q;       // Direction of the current burst.
    logic [ADDR_W-1:0]      adr_q;      // Burst base address.
    logic [DATA_W-1:0]      value_q;    // Same value for all four words.

    // Read-back words, indexed by position in the burst.
    logic [DATA_W-1:0]      rd_buf [BURST_LEN];

    logic                   word_ack;
    logic                   last_word;

    assign word_ack  = wb_stb & wb_ack;                        // One word completes.
    assign last_word = word_cnt == BURST_IDX_W'(BURST_LEN - 1);

    ////////////////////////////////////////////////////////////
    // Bus cycle control.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            wb_cyc     <= 1'b0;
            wb_stb     <= 1'b0;
            we_q       <= 1'b0;
            word_cnt   <= '0;
            burst_done <= 1'b0;
        end else begin
            burst_done <= 1'b0;                                // Pulse only.
            if (start && !wb_cyc) begin
                // Bus goes active on the next cycle.
                wb_cyc   <= 1'b1;
                wb_stb   <= 1'b1;
                we_q     <= write;
                word_cnt <= '0;
            end else if (wb_cyc) begin
                if (word_ack) begin
                    wb_stb <= 1'b0;                            // Drop stb after each ack.
                    if (last_word) begin
                        wb_cyc     <= 1'b0;                    // Burst finished.
                        we_q       <= 1'b0;
                        burst_done <= 1'b1;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end else if (!wb_stb) begin
                    wb_stb <= 1'b1;                            // Next word after the gap.
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Request capture and read-back buffer.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210) begin
        if (start && !wb_cyc) begin
            adr_q   <= base_adr;
            value_q <= wr_value;
        end
        // Sample read data in the ack cycle.
        if (word_ack && !we_q) begin
            rd_buf[word_cnt] <= wb_dat_r;
        end
    end

    assign wb_we    = we_q;
    assign wb_adr   = adr_q + ADDR_W'(word_cnt);               // base .. base+3.
    assign wb_dat_w = value_q;

    assign rd_word  = rd_buf[rd_idx];                          // Sequencer picks a word.

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SDRAM self-test bench with Verilator.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_sdram_self_test \
    -f all.f -Mdir obj_dir > build.log 2>&1 &&
./obj_dir/Vtb_sdram_self_test > sim.log 2>&1 &&
cat sim.log &&
! grep -q "tests failed" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== test/tb_sdram_self_test.sv ====
`timescale 1ns/1ps

module tb_sdram_self_test
    import sdram_test_pkg::*;
();

    localparam int BAUD        = 8;       // Short frames.
    localparam int GAP         = 20;
    localparam int WORDS       = 16;      // Four bursts.
    localparam int RUN_LIMIT   = 20000;   // Cycles allowed for one run.
    localparam int IDLE_CYCLES = 500;

    logic              clk_133MHz_210;
    logic              rst_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_w;
    logic [DATA_W-1:0] wb_dat_r = '0;
    logic              wb_ack   = 1'b0;
    logic              uart_txd;
    logic              err_led;
    logic              done;

    int errors, test_mark, tests_ok, tests_bad;
    int bus_errs, frame_errs;

    // Memory model.
    logic [DATA_W-1:0] mem [64];
    int                wr_cnt, rd_cnt, wait_left;
    logic              pending, last_stb;
    logic              fault_en;
    int                fault_word, fault_bit;

    // UART receiver.
    logic              rx_active;
    int                rx_cnt;
    logic [3:0]        rx_idx;
    logic [10:0]       rx_bits;
    logic [7:0]        rx_q [$];
    logic [7:0]        exp_q [$];

    sdram_self_test_top #(
        .BAUD_DIV     (BAUD),
        .GAP_CYCLES   (GAP),
        .REGION_WORDS (WORDS)
    ) i_sdram_self_test_top (.*);

    initial begin
        clk_133MHz_210 = 1'b0;
        forever #20 clk_133MHz_210 = ~clk_133MHz_210;   // 40 ns period.
    end

    function automatic int compare_value(input string name, input logic [31:0] exp,
                                         input logic [31:0] act);
        compare_value = 0;
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
            compare_value = 1;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Wishbone slave with random wait states.
    ////////////////////////////////////////////////////////////

    always @(negedge clk_133MHz_210) begin
        if (!rst_n) begin
            wb_ack   = 1'b0;
            pending  = 1'b0;
            last_stb = 1'b0;
            wr_cnt   = 0;
            rd_cnt   = 0;
        end else begin
            if (last_stb && !wb_ack) begin                  // Stb held until ack.
                bus_errs += compare_value("bus stb before ack", 32'd1, 32'(wb_stb));
            end
            last_stb = wb_stb;
            if (wb_ack) begin
                wb_ack = 1'b0;                              // One-cycle ack.
            end else if (wb_stb) begin
                if (!pending) begin
                    pending   = 1'b1;
                    wait_left = $urandom_range(3, 0);
                end
                if (wait_left > 0) begin
                    wait_left--;
                end else begin
                    pending = 1'b0;
                    wb_ack  = 1'b1;
                    if (wb_we) begin
                        // Burst n writes n to 4n .. 4n+3.
                        bus_errs += compare_value("bus write address", 32'(wr_cnt),
                                                  32'(wb_adr));
                        bus_errs += compare_value("bus write data", 32'(wr_cnt / 4),
                                                  32'(wb_dat_w));
                        mem[wb_adr[5:0]] = wb_dat_w;
                        wr_cnt++;
                    end else begin
                        bus_errs += compare_value("bus read address", 32'(rd_cnt),
                                                  32'(wb_adr));
                        wb_dat_r = mem[wb_adr[5:0]];
                        if (fault_en && wb_adr == 24'(fault_word)) begin
                            wb_dat_r = wb_dat_r ^ 16'(32'd1 << fault_bit);   // Injected fault.
                        end
                        rd_cnt++;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // UART receiver, mid-bit sampling.
    ////////////////////////////////////////////////////////////

    always @(negedge clk_133MHz_210) begin
        if (!rst_n) begin
            rx_active = 1'b0;
        end else if (!rx_active) begin
            if (!uart_txd) begin
                rx_active = 1'b1;                           // Start bit edge.
                rx_cnt    = 0;
            end
        end else begin
            rx_cnt++;
            if (rx_cnt % BAUD == BAUD / 2) begin
                rx_idx          = 4'(rx_cnt / BAUD);
                rx_bits[rx_idx] = uart_txd;
                if (rx_idx == 4'(UART_FRAME_BITS - 1)) begin
                    frame_errs += compare_value("frame start bit", 32'd0, 32'(rx_bits[0]));
                    frame_errs += compare_value("frame stop bits", 32'd3,
                                                32'(rx_bits[10:9]));
                    rx_q.push_back(rx_bits[8:1]);
                    rx_active = 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Helper tasks.
    ////////////////////////////////////////////////////////////

    task automatic check_idle(input string name);
        errors += compare_value({name, " wb_cyc"}, 32'd0, 32'(wb_cyc));
        errors += compare_value({name, " wb_stb"}, 32'd0, 32'(wb_stb));
        errors += compare_value({name, " wb_we"}, 32'd0, 32'(wb_we));
        errors += compare_value({name, " err_led"}, 32'd0, 32'(err_led));
        errors += compare_value({name, " done"}, 32'd0, 32'(done));
        errors += compare_value({name, " uart_txd"}, 32'd1, 32'(uart_txd));
    endtask

    task automatic reset_dut(input string name);
        rst_n = 1'b0;
        rx_q.delete();
        repeat (4) begin
            @(negedge clk_133MHz_210);
            check_idle(name);
        end
        rst_n = 1'b1;
        @(negedge clk_133MHz_210);
        check_idle(name);                                   // Just after release.
    endtask

    task automatic wait_for_end(input string name);
        int n;
        n = 0;
        while (!done && !err_led && n < RUN_LIMIT) begin
            @(negedge clk_133MHz_210);
            n++;
        end
        if (n >= RUN_LIMIT) begin
            $display("%s: timed out, neither done nor err_led rose in %0d cycles",
                     name, RUN_LIMIT);
            errors++;
        end
    endtask

    task automatic check_no_cyc(input string name);
        int seen;
        seen = 0;
        repeat (IDLE_CYCLES) begin
            @(negedge clk_133MHz_210);
            if (wb_cyc) seen++;
        end
        errors += compare_value({name, " cycles with wb_cyc"}, 32'd0, 32'(seen));
    endtask

    // High then low byte of the burst number, per word.
    function automatic void build_expected(input int words, input bit with_err);
        exp_q.delete();
        for (int i = 0; i < words; i++) begin
            exp_q.push_back(8'((i / 4) >> 8));
            exp_q.push_back(8'(i / 4));
        end
        if (with_err) exp_q.push_back(ERR_BYTE);
    endfunction

    task automatic compare_stream(input string name);
        errors += compare_value({name, " byte count"}, 32'(exp_q.size()), 32'(rx_q.size()));
        for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            errors += compare_value($sformatf("%s byte %0d", name, i), 32'(exp_q[i]),
                                    32'(rx_q[i]));
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_mark) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, errors - test_mark);
            tests_bad++;
        end
        test_mark = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////////////////////////

    initial begin
        int bytes_at_end;
        int bus_mark;
        int frame_mark;
        void'($urandom(32'h3ca));
        rst_n      = 1'b0;
        fault_en   = 1'b0;
        fault_word = 0;
        fault_bit  = 0;

        reset_dut("reset_state");
        end_test("reset_state");

        wait_for_end("clean run");                          // Four clean bursts.
        bytes_at_end = rx_q.size();

        errors += compare_value("bus_sequence write words", WORDS, wr_cnt);
        errors += compare_value("bus_sequence read words", WORDS, rd_cnt);
        errors += compare_value("bus_sequence monitor errors", 0, bus_errs);
        end_test("bus_sequence");

        build_expected(WORDS, 1'b0);
        compare_stream("report_stream");
        errors += compare_value("report_stream frame errors", 0, frame_errs);
        end_test("report_stream");

        errors += compare_value("completion done", 32'd1, 32'(done));
        errors += compare_value("completion bytes at done", 2 * WORDS, bytes_at_end);
        errors += compare_value("completion err_led", 32'd0, 32'(err_led));
        check_no_cyc("completion");
        errors += compare_value("completion done held", 32'd1, 32'(done));
        end_test("completion");

        // Flip one bit of one read word.
        fault_word = $urandom_range(WORDS - 1, 0);
        fault_bit  = $urandom_range(DATA_W - 1, 0);
        fault_en   = 1'b1;
        bus_mark   = bus_errs;
        frame_mark = frame_errs;
        $display("error_halt: fault on word %0d, bit %0d", fault_word, fault_bit);
        reset_dut("error_halt reset");
        wait_for_end("error run");
        build_expected(fault_word, 1'b1);
        compare_stream("error_halt");
        errors += compare_value("error_halt err_led", 32'd1, 32'(err_led));
        errors += compare_value("error_halt done", 32'd0, 32'(done));
        check_no_cyc("error_halt");
        errors += compare_value("error_halt done after idle", 32'd0, 32'(done));
        errors += compare_value("error_halt monitor errors", bus_mark, bus_errs);
        errors += compare_value("error_halt frame errors", frame_mark, frame_errs);
        end_test("error_halt");

        $display("summary: %0d tests, %0d ok, %0d with errors, %0d check errors",
                 tests_ok + tests_bad, tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
